/* logic/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and register file geometry
`define XLEN 32
`define REG_ADDR_W 5
`define NUM_REGS 32

// Boot vector
`define RESET_PC 32'hBFC0_0000

// All four byte lanes of a word store
`define WORD_WEN 4'b1111

`endif

/* logic/core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // Second operand source, or shamt as first operand for shifts
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM_SEXT,
        SRC_IMM_ZEXT,
        SRC_SHAMT
    } alu_src_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_type_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JUMP
    } branch_kind_e;

    typedef struct packed {
        alu_op_e                 alu_op;
        alu_src_e                alu_src;
        mem_type_e               mem_type;
        branch_kind_e            branch_kind;
        logic                    wb_en;
        logic [`REG_ADDR_W-1:0]  wb_dest;
    } decode_t;

    typedef struct packed {
        logic                valid;
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    instr;
    } if_id_t;

    // Immediate, shamt and jump index all live in field
    typedef struct packed {
        logic                valid;
        logic [`XLEN-1:0]    pc;
        decode_t             ctrl;
        logic [`XLEN-1:0]    rs_value;
        logic [`XLEN-1:0]    rt_value;
        logic [25:0]         field;
    } id_ex_t;

    typedef struct packed {
        logic                    valid;
        logic [`XLEN-1:0]        result;
        logic [`XLEN-1:0]        store_data;
        mem_type_e               mem_type;
        logic                    wb_en;
        logic [`REG_ADDR_W-1:0]  wb_dest;
    } ex_mem_t;

    typedef struct packed {
        logic                    en;
        logic [`REG_ADDR_W-1:0]  dest;
        logic [`XLEN-1:0]        data;
    } reg_write_t;

endpackage

/* logic/fetch_pc.sv */
`include "core_defs.svh"

module fetch_pc (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               fetch_en,
    input  logic               inst_ok,
    input  logic               branch_taken,
    input  logic [`XLEN-1:0]   branch_target,
    output logic [`XLEN-1:0]   pc
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else if (branch_taken) begin
            // Redirect wins over a fetch accepted in the same cycle
            pc <= branch_target;
        end else if (fetch_en && inst_ok) begin
            pc <= pc + `XLEN'd4;
        end
    end

endmodule

/* logic/decoder.sv */
`include "core_defs.svh"

module decoder (
    input  logic [`XLEN-1:0]   instr,
    output core_pkg::decode_t  ctrl
);

    import core_pkg::*;

    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;

    assign rt = instr[20:16];
    assign rd = instr[15:11];

    always_comb begin
        // Undefined encodings fall through as a no-op
        ctrl = '{alu_op: ALU_ADD, alu_src: SRC_REG, mem_type: MEM_NONE,
                 branch_kind: BR_NONE, wb_en: 1'b0, wb_dest: rt};

        case (opcode_e'(instr[31:26]))
            OP_SPECIAL: begin
                ctrl.wb_dest = rd;
                ctrl.wb_en = 1'b1;
                case (funct_e'(instr[5:0]))
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLL: begin
                        ctrl.alu_op = ALU_SLL;
                        ctrl.alu_src = SRC_SHAMT;
                    end
                    FN_SRL: begin
                        ctrl.alu_op = ALU_SRL;
                        ctrl.alu_src = SRC_SHAMT;
                    end
                    default: ctrl.wb_en = 1'b0;
                endcase
            end
            OP_ADDIU, OP_SLTI: begin
                ctrl.alu_op = (instr[31:26] == OP_SLTI) ? ALU_SLT : ALU_ADD;
                ctrl.alu_src = SRC_IMM_SEXT;
                ctrl.wb_en = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                case (opcode_e'(instr[31:26]))
                    OP_ANDI: ctrl.alu_op = ALU_AND;
                    OP_ORI:  ctrl.alu_op = ALU_OR;
                    OP_XORI: ctrl.alu_op = ALU_XOR;
                    default: ctrl.alu_op = ALU_LUI;
                endcase
                ctrl.alu_src = SRC_IMM_ZEXT;
                ctrl.wb_en = 1'b1;
            end
            OP_LW: begin
                ctrl.alu_src = SRC_IMM_SEXT;
                ctrl.mem_type = MEM_LOAD;
                ctrl.wb_en = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_src = SRC_IMM_SEXT;
                ctrl.mem_type = MEM_STORE;
            end
            OP_BEQ:  ctrl.branch_kind = BR_BEQ;
            OP_BNE:  ctrl.branch_kind = BR_BNE;
            OP_J:    ctrl.branch_kind = BR_JUMP;
            default: ctrl.wb_en = 1'b0;
        endcase

        // $zero is never written
        if (ctrl.wb_dest == '0) begin
            ctrl.wb_en = 1'b0;
        end
    end

endmodule

/* logic/register_file.sv */
`include "core_defs.svh"

module register_file (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`REG_ADDR_W-1:0]   rs_addr,
    input  logic [`REG_ADDR_W-1:0]   rt_addr,
    input  core_pkg::reg_write_t     write,
    output logic [`XLEN-1:0]         rs_data,
    output logic [`XLEN-1:0]         rt_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // Bypass the write port so decode sees this cycle's writeback
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (write.en && write.dest == addr) begin
            return write.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write.en && write.dest != '0) begin
            regs[write.dest] <= write.data;
        end
    end

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

/* logic/forwarding_unit.sv */
`include "core_defs.svh"

module forwarding_unit (
    input  logic [`REG_ADDR_W-1:0]   reg_addr,
    input  logic [`XLEN-1:0]         reg_data,
    input  core_pkg::reg_write_t     ex_fwd,
    input  core_pkg::reg_write_t     mem_fwd,
    output logic [`XLEN-1:0]         value
);

    // Youngest producer first
    always_comb begin
        if (reg_addr != '0 && ex_fwd.en && ex_fwd.dest == reg_addr) begin
            value = ex_fwd.data;
        end else if (reg_addr != '0 && mem_fwd.en && mem_fwd.dest == reg_addr) begin
            value = mem_fwd.data;
        end else begin
            value = reg_data;
        end
    end

endmodule

/* logic/alu.sv */
`include "core_defs.svh"

module alu (
    input  core_pkg::id_ex_t   op,
    output logic [`XLEN-1:0]   result
);

    import core_pkg::*;

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [15:0]      imm;

    assign imm = op.field[15:0];

    always_comb begin
        a = op.rs_value;
        b = op.rt_value;
        case (op.ctrl.alu_src)
            SRC_IMM_SEXT: b = {{(`XLEN-16){imm[15]}}, imm};
            SRC_IMM_ZEXT: b = {{(`XLEN-16){1'b0}}, imm};
            SRC_SHAMT:    a = {{(`XLEN-5){1'b0}}, op.field[10:6]};
            default:      b = op.rt_value;
        endcase
    end

    always_comb begin
        case (op.ctrl.alu_op)
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLL: result = b << a[4:0];
            ALU_SRL: result = b >> a[4:0];
            ALU_LUI: result = {b[15:0], 16'h0000};
            // Also the load and store address
            default: result = a + b;
        endcase
    end

endmodule

/* logic/branch_unit.sv */
`include "core_defs.svh"

module branch_unit (
    input  core_pkg::id_ex_t   op,
    output logic               taken,
    output logic [`XLEN-1:0]   target
);

    import core_pkg::*;

    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] offset;

    assign pc_plus4 = op.pc + `XLEN'd4;
    assign offset = {{(`XLEN-18){op.field[15]}}, op.field[15:0], 2'b00};

    always_comb begin
        case (op.ctrl.branch_kind)
            BR_BEQ:  taken = op.valid && (op.rs_value == op.rt_value);
            BR_BNE:  taken = op.valid && (op.rs_value != op.rt_value);
            BR_JUMP: taken = op.valid;
            default: taken = 1'b0;
        endcase
    end

    // J keeps the 256 MB region of the next pc
    assign target = (op.ctrl.branch_kind == BR_JUMP) ?
                    {pc_plus4[`XLEN-1:28], op.field, 2'b00} : pc_plus4 + offset;

endmodule

/* logic/pipe_ctrl.sv */
`include "core_defs.svh"

module pipe_ctrl (
    input  logic                     inst_stall,
    input  logic                     data_stall,
    input  logic                     branch_taken,
    input  logic                     load_in_ex,
    input  logic [`REG_ADDR_W-1:0]   ex_dest,
    input  logic [`REG_ADDR_W-1:0]   id_rs,
    input  logic [`REG_ADDR_W-1:0]   id_rt,
    output logic                     fetch_en,
    output logic                     if_id_en,
    output logic                     if_id_squash,
    output logic                     id_ex_en,
    output logic                     id_ex_bubble,
    output logic                     ex_mem_en,
    output logic                     mem_wb_en
);

    logic load_use;

    assign load_use = load_in_ex &&
                      ((id_rs != '0 && id_rs == ex_dest) || (id_rt != '0 && id_rt == ex_dest));

    // Data port back-pressure freezes everything
    assign fetch_en  = !data_stall && !load_use;
    assign if_id_en  = !data_stall && !load_use;
    assign id_ex_en  = !data_stall;
    assign ex_mem_en = !data_stall;
    assign mem_wb_en = !data_stall;

    // A missed fetch leaves a bubble in IF/ID
    assign if_id_squash = !data_stall && (branch_taken || (fetch_en && inst_stall));
    assign id_ex_bubble = !data_stall && (branch_taken || load_use);

endmodule

/* logic/sirius_core.sv */
`include "core_defs.svh"

module sirius_core (
    input  logic               clk,
    input  logic               arst_n,
    output logic               inst_en,
    output logic [`XLEN-1:0]   inst_addr,
    input  logic               inst_ok,
    input  logic [`XLEN-1:0]   inst_data,
    output logic               data_en,
    output logic [3:0]         data_wen,
    output logic [`XLEN-1:0]   data_addr,
    output logic [`XLEN-1:0]   data_wdata,
    input  logic               data_ok,
    input  logic [`XLEN-1:0]   data_data
);

    import core_pkg::*;

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    reg_write_t  mem_wb;

    logic fetch_en;
    logic if_id_en;
    logic if_id_squash;
    logic id_ex_en;
    logic id_ex_bubble;
    logic ex_mem_en;
    logic mem_wb_en;
    logic data_stall;
    logic load_in_ex;

    logic [`XLEN-1:0] pc;
    decode_t          id_ctrl;
    logic [`XLEN-1:0] rs_reg;
    logic [`XLEN-1:0] rt_reg;
    logic [`XLEN-1:0] rs_value;
    logic [`XLEN-1:0] rt_value;
    reg_write_t       ex_fwd;
    reg_write_t       mem_fwd;
    logic [`XLEN-1:0] alu_result;
    logic             ex_taken;
    logic [`XLEN-1:0] ex_target;
    logic [`XLEN-1:0] mem_result;

    assign inst_en = fetch_en;
    assign inst_addr = pc;

    assign data_stall = data_en && !data_ok;
    assign load_in_ex = id_ex.valid && id_ex.ctrl.mem_type == MEM_LOAD;

    pipe_ctrl pipe_ctrl_i (
        .inst_stall   (!inst_ok),
        .data_stall   (data_stall),
        .branch_taken (ex_taken),
        .load_in_ex   (load_in_ex),
        .ex_dest      (id_ex.ctrl.wb_dest),
        .id_rs        (if_id.instr[25:21]),
        .id_rt        (if_id.instr[20:16]),
        .fetch_en     (fetch_en),
        .if_id_en     (if_id_en),
        .if_id_squash (if_id_squash),
        .id_ex_en     (id_ex_en),
        .id_ex_bubble (id_ex_bubble),
        .ex_mem_en    (ex_mem_en),
        .mem_wb_en    (mem_wb_en)
    );

    // Redirect only once the branch leaves execute
    fetch_pc fetch_pc_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_en      (fetch_en),
        .inst_ok       (inst_ok),
        .branch_taken  (ex_taken && ex_mem_en),
        .branch_target (ex_target),
        .pc            (pc)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id.valid <= 1'b0;
        end else if (if_id_squash) begin
            if_id.valid <= 1'b0;
        end else if (if_id_en) begin
            if_id <= '{valid: 1'b1, pc: pc, instr: inst_data};
        end
    end

    decoder decoder_i (
        .instr (if_id.instr),
        .ctrl  (id_ctrl)
    );

    register_file register_file_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (if_id.instr[25:21]),
        .rt_addr (if_id.instr[20:16]),
        .write   (mem_wb),
        .rs_data (rs_reg),
        .rt_data (rt_reg)
    );

    // Load results are not ready in execute
    assign ex_fwd = '{en: id_ex.valid && id_ex.ctrl.wb_en && id_ex.ctrl.mem_type != MEM_LOAD,
                      dest: id_ex.ctrl.wb_dest, data: alu_result};
    assign mem_result = (ex_mem.mem_type == MEM_LOAD) ? data_data : ex_mem.result;
    assign mem_fwd = '{en: ex_mem.valid && ex_mem.wb_en, dest: ex_mem.wb_dest,
                       data: mem_result};

    forwarding_unit forward_rs_i (
        .reg_addr (if_id.instr[25:21]),
        .reg_data (rs_reg),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .value    (rs_value)
    );

    forwarding_unit forward_rt_i (
        .reg_addr (if_id.instr[20:16]),
        .reg_data (rt_reg),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .value    (rt_value)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex.valid <= 1'b0;
        end else if (id_ex_en) begin
            if (id_ex_bubble) begin
                id_ex.valid <= 1'b0;
            end else begin
                id_ex <= '{valid: if_id.valid, pc: if_id.pc, ctrl: id_ctrl,
                           rs_value: rs_value, rt_value: rt_value, field: if_id.instr[25:0]};
            end
        end
    end

    alu alu_i (
        .op     (id_ex),
        .result (alu_result)
    );

    branch_unit branch_unit_i (
        .op     (id_ex),
        .taken  (ex_taken),
        .target (ex_target)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem.valid <= 1'b0;
        end else if (ex_mem_en) begin
            ex_mem <= '{valid: id_ex.valid, result: alu_result, store_data: id_ex.rt_value,
                        mem_type: id_ex.ctrl.mem_type, wb_en: id_ex.ctrl.wb_en,
                        wb_dest: id_ex.ctrl.wb_dest};
        end
    end

    // Port outputs come straight from EX/MEM and hold while stalled
    assign data_en = ex_mem.valid && ex_mem.mem_type != MEM_NONE;
    assign data_wen = (ex_mem.valid && ex_mem.mem_type == MEM_STORE) ? `WORD_WEN : 4'b0000;
    assign data_addr = ex_mem.result;
    assign data_wdata = ex_mem.store_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb.en <= 1'b0;
        end else begin
            mem_wb.en <= mem_wb_en && ex_mem.valid && ex_mem.wb_en;
            if (mem_wb_en) begin
                mem_wb.dest <= ex_mem.wb_dest;
                mem_wb.data <= mem_result;
            end
        end
    end

endmodule

/* test/sirius_tb.sv */
`include "core_defs.svh"

module sirius_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } store_t;

    typedef struct packed {
        logic             en;
        logic [3:0]       wen;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } port_t;

    localparam int IMEM_WORDS = 64;
    localparam int RUN_LIMIT = 2000;

    logic             clk;
    logic             arst_n;
    logic             inst_en;
    logic [`XLEN-1:0] inst_addr;
    logic             inst_ok;
    logic [`XLEN-1:0] inst_data;
    logic             data_en;
    logic [3:0]       data_wen;
    logic [`XLEN-1:0] data_addr;
    logic [`XLEN-1:0] data_wdata;
    logic             data_ok;
    logic [`XLEN-1:0] data_data;

    logic [`XLEN-1:0] imem [IMEM_WORDS];
    logic [`XLEN-1:0] dut_mem [logic [`XLEN-1:0]];
    logic [`XLEN-1:0] model_mem [logic [`XLEN-1:0]];
    store_t           expected [$];
    int               prog_len;
    int               store_idx;
    int               errors;
    int               checks;
    int               cycles;
    int               seed;
    bit               stall_mode;
    bit               held;
    port_t            hold;

    sirius_core sirius_core_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_en    (inst_en),
        .inst_addr  (inst_addr),
        .inst_ok    (inst_ok),
        .inst_data  (inst_data),
        .data_en    (data_en),
        .data_wen   (data_wen),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_ok    (data_ok),
        .data_data  (data_data)
    );

    function automatic logic [31:0] r_op(funct_e fn, logic [4:0] rs, logic [4:0] rt,
                                         logic [4:0] rd, logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_op(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_op(logic [31:0] addr);
        return {OP_J, addr[27:2]};
    endfunction

    // Untouched words differ for every address
    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3C5A_96E1;
    endfunction

    function automatic logic [31:0] imem_read(logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `RESET_PC) >> 2;
        if (idx < IMEM_WORDS) begin
            return imem[idx];
        end
        return 32'h0;
    endfunction

    function automatic logic [31:0] dut_read(logic [31:0] addr);
        if (dut_mem.exists(addr)) begin
            return dut_mem[addr];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [31:0] model_read(logic [31:0] addr);
        if (model_mem.exists(addr)) begin
            return model_mem[addr];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [31:0] here();
        return `RESET_PC + 32'(prog_len * 4);
    endfunction

    task automatic emit(logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // ISA interpreter without delay slots that collects the expected stores
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] next;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_s;
        logic [31:0] imm_z;
        logic [31:0] tgt;
        bit          done;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 0;
        end
        pc = `RESET_PC;
        done = 0;
        expected.delete();
        model_mem.delete();
        for (int step = 0; step < 1000 && !done; step++) begin
            ins = imem_read(pc);
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            imm_s = {{16{ins[15]}}, ins[15:0]};
            imm_z = {16'h0, ins[15:0]};
            next = pc + 4;
            case (ins[31:26])
                OP_SPECIAL: begin
                    case (ins[5:0])
                        FN_ADDU: regs[ins[15:11]] = a + b;
                        FN_SUBU: regs[ins[15:11]] = a - b;
                        FN_AND:  regs[ins[15:11]] = a & b;
                        FN_OR:   regs[ins[15:11]] = a | b;
                        FN_XOR:  regs[ins[15:11]] = a ^ b;
                        FN_SLT:  regs[ins[15:11]] = {31'h0, $signed(a) < $signed(b)};
                        FN_SLL:  regs[ins[15:11]] = b << ins[10:6];
                        FN_SRL:  regs[ins[15:11]] = b >> ins[10:6];
                        default: ;
                    endcase
                end
                OP_ADDIU: regs[ins[20:16]] = a + imm_s;
                OP_SLTI:  regs[ins[20:16]] = {31'h0, $signed(a) < $signed(imm_s)};
                OP_ANDI:  regs[ins[20:16]] = a & imm_z;
                OP_ORI:   regs[ins[20:16]] = a | imm_z;
                OP_XORI:  regs[ins[20:16]] = a ^ imm_z;
                OP_LUI:   regs[ins[20:16]] = {ins[15:0], 16'h0};
                OP_LW:    regs[ins[20:16]] = model_read(a + imm_s);
                OP_SW: begin
                    model_mem[a + imm_s] = b;
                    expected.push_back(store_t'{addr: a + imm_s, data: b});
                end
                OP_BEQ: if (a == b) next = pc + 4 + (imm_s << 2);
                OP_BNE: if (a != b) next = pc + 4 + (imm_s << 2);
                OP_J: begin
                    tgt = {next[31:28], ins[25:0], 2'b00};
                    done = (tgt == pc);
                    next = tgt;
                end
                default: ;
            endcase
            regs[0] = 0;
            pc = next;
        end
    endtask

    // Dependent ALU chain through every arithmetic and immediate op
    task automatic load_alu_prog();
        prog_len = 0;
        emit(i_op(OP_ADDIU, 0, 1, 16'h1234));
        emit(i_op(OP_ADDIU, 1, 2, 16'hFFFB));
        emit(r_op(FN_ADDU, 1, 2, 3, 0));
        emit(r_op(FN_SUBU, 3, 1, 4, 0));
        emit(r_op(FN_AND, 4, 3, 5, 0));
        emit(r_op(FN_OR, 5, 2, 6, 0));
        emit(r_op(FN_XOR, 6, 1, 7, 0));
        emit(r_op(FN_SLT, 2, 7, 8, 0));
        emit(r_op(FN_SLL, 0, 7, 9, 4));
        emit(r_op(FN_SRL, 0, 9, 11, 3));
        emit(i_op(OP_ORI, 0, 10, 16'h1000));
        emit(i_op(OP_SW, 10, 11, 16'h0000));
        emit(i_op(OP_SLTI, 11, 12, 16'hFFFF));
        emit(i_op(OP_ANDI, 11, 13, 16'hFF0F));
        emit(i_op(OP_ORI, 13, 14, 16'h8001));
        emit(i_op(OP_XORI, 14, 15, 16'h5555));
        emit(i_op(OP_LUI, 0, 16, 16'hDEAD));
        emit(r_op(FN_ADDU, 16, 15, 17, 0));
        emit(i_op(OP_SW, 10, 17, 16'h0004));
        emit(i_op(OP_SW, 10, 12, 16'h0008));
        emit(i_op(OP_SW, 10, 8, 16'h000C));
        emit(i_op(OP_ADDIU, 0, 2, 16'hFF9C));
        emit(r_op(FN_SLT, 2, 1, 3, 0));
        emit(i_op(OP_SW, 10, 3, 16'h0010));
        emit(r_op(FN_SUBU, 2, 17, 4, 0));
        emit(r_op(FN_SRL, 0, 4, 5, 7));
        emit(r_op(FN_XOR, 5, 4, 0, 0));
        emit(i_op(OP_SW, 10, 5, 16'h0014));
        emit(i_op(OP_SW, 10, 0, 16'h0018));
        emit(j_op(here()));
    endtask

    // Loads, load-use, and taken and untaken branches
    task automatic load_mem_prog();
        prog_len = 0;
        emit(i_op(OP_ORI, 0, 10, 16'h2000));
        emit(i_op(OP_LW, 10, 1, 16'h0000));
        emit(r_op(FN_ADDU, 1, 1, 2, 0));
        emit(i_op(OP_SW, 10, 2, 16'h0040));
        emit(i_op(OP_LW, 10, 3, 16'h0040));
        emit(i_op(OP_SW, 10, 3, 16'h0044));
        emit(i_op(OP_LW, 10, 4, 16'h0004));
        emit(i_op(OP_BEQ, 4, 4, 16'h0002));
        emit(i_op(OP_SW, 10, 4, 16'h0048));
        emit(i_op(OP_SW, 10, 4, 16'h004C));
        emit(i_op(OP_SW, 10, 1, 16'h0050));
        emit(i_op(OP_BNE, 1, 1, 16'h0001));
        emit(i_op(OP_SW, 10, 2, 16'h0054));
        emit(i_op(OP_BEQ, 1, 2, 16'h0001));
        emit(i_op(OP_SW, 10, 3, 16'h0058));
        emit(i_op(OP_BNE, 1, 2, 16'h0002));
        emit(i_op(OP_SW, 10, 1, 16'h005C));
        emit(i_op(OP_SW, 10, 1, 16'h0060));
        emit(i_op(OP_SW, 10, 4, 16'h0064));
        emit(j_op(here() + 12));
        emit(i_op(OP_SW, 10, 2, 16'h0068));
        emit(i_op(OP_SW, 10, 2, 16'h006C));
        emit(i_op(OP_LW, 10, 5, 16'h0008));
        emit(i_op(OP_BNE, 5, 0, 16'h0001));
        emit(i_op(OP_SW, 10, 5, 16'h0070));
        emit(r_op(FN_XOR, 5, 1, 6, 0));
        emit(i_op(OP_SW, 10, 6, 16'h0074));
        emit(i_op(OP_LW, 10, 7, 16'h0074));
        emit(i_op(OP_SW, 10, 7, 16'h0078));
        emit(j_op(here()));
    endtask

    task automatic check_idle_outputs();
        checks++;
        assert (!data_en && data_wen == 4'b0000 && inst_en && inst_addr == `RESET_PC)
        else begin
            $display("error %0t: outputs after reset en=%b wen=%h inst_en=%b addr=%h",
                     $time, data_en, data_wen, inst_en, inst_addr);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 arst_n = 0;
        dut_mem.delete();
        repeat (5) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        #1 arst_n = 1;
        #1 check_idle_outputs();
    endtask

    task automatic run_phase(input bit stalls);
        run_model();
        stall_mode = stalls;
        store_idx = 0;
        held = 0;
        apply_reset();
        while (store_idx < expected.size()) begin
            @(negedge clk);
        end
        // Time for a squashed store to show up
        repeat (20) @(negedge clk);
    endtask

    initial begin
        clk = 0;
        forever #4 clk = ~clk;
    end

    // Memory responses a short delay after the edge
    always @(posedge clk) begin
        #1;
        inst_ok = stall_mode ? (($random(seed) & 32'h7FFF_FFFF) % 10 < 7) : 1'b1;
        data_ok = stall_mode ? (($random(seed) & 32'h7FFF_FFFF) % 10 < 7) : 1'b1;
        inst_data = imem_read(inst_addr);
        data_data = dut_read(data_addr);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= RUN_LIMIT) begin
            $display("run timed out after %0d cycles with %0d stores seen",
                     RUN_LIMIT, store_idx);
            $display("Testbench failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (arst_n) begin
            if (held) begin
                checks++;
                assert (data_addr == hold.addr && data_wdata == hold.wdata &&
                        data_wen == hold.wen && data_en == hold.en)
                else begin
                    $display("error %0t: data port changed while stalled", $time);
                    errors++;
                end
            end
            held = data_en && !data_ok;
            hold = '{en: data_en, wen: data_wen, addr: data_addr, wdata: data_wdata};
            if (data_en && data_ok && data_wen == `WORD_WEN) begin
                dut_mem[data_addr] = data_wdata;
                checks++;
                assert (store_idx < expected.size())
                else begin
                    $display("error %0t: unexpected store to %h", $time, data_addr);
                    errors++;
                end
                if (store_idx < expected.size()) begin
                    checks++;
                    assert (data_addr == expected[store_idx].addr &&
                            data_wdata == expected[store_idx].data)
                    else begin
                        $display("error %0t: store %0d got %h <- %h, expected %h <- %h",
                                 $time, store_idx, data_addr, data_wdata,
                                 expected[store_idx].addr, expected[store_idx].data);
                        errors++;
                    end
                    store_idx++;
                end
            end
        end
    end

    initial begin
        arst_n = 0;
        inst_ok = 0;
        inst_data = 0;
        data_ok = 0;
        data_data = 0;
        seed = 98778;
        errors = 0;
        checks = 0;
        cycles = 0;
        stall_mode = 0;
        held = 0;
        load_alu_prog();
        run_phase(0);
        run_phase(1);
        load_mem_prog();
        run_phase(0);
        run_phase(1);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/core_pkg.sv
logic/fetch_pc.sv
logic/decoder.sv
logic/register_file.sv
logic/forwarding_unit.sv
logic/alu.sv
logic/branch_unit.sv
logic/pipe_ctrl.sv
logic/sirius_core.sv
test/sirius_tb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module sirius_tb -o sirius_sim \
    && ./obj_dir/sirius_sim | tee /dev/stderr | grep -q "Testbench passed" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
